// ==== runSim.sh ====
#!/bin/sh
# Compile and run the register bank testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module BsrRegGprTb \
	-f sources.f && ./obj_dir/VBsrRegGprTb 2>&1 | tee sim.log
grep -q "^TB PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
verilog/BsrRegPkg.sv
verilog/BsrRegIdDecode.sv
verilog/BsrBankedLane.sv
verilog/BsrSysRegFile.sv
verilog/BsrReadPorts.sv
verilog/BsrRegGpr.sv
testbench/BsrRegGpr_assert.sv
testbench/BsrRegGprTb.sv

// ==== testbench/BsrRegGprTb.sv ====
// Register bank testbench
`timescale 1ns/1ns
`default_nettype none

module BsrRegGprTb;
	import BsrRegPkg::*;

	localparam int NumRows = 19;
	localparam int ResetCycles = 3;
	localparam int CycleLimit = NumRows + ResetCycles + 20;
	localparam logic [31:0] ImmVal = 32'h1234ABCD;
	localparam logic [31:0] PcVal = 32'h00004000;
	localparam logic [31:0] PcExp = PcVal + 32'd2;		// PC reads two ahead

	typedef struct packed {
		logic [2:0] flags;			// Bank bit, exHold, check sysOut
		regId_t wrId;
		logic [31:0] wrVal;
		logic [7:0] seed;			// exNext pattern
		regId_t idM;
		regId_t idN;
		logic [31:0] expM;
		logic [31:0] expN;
		logic [7:0] sysSeed;		// Expected sysOut pattern
		logic [7:0] vbrSeed;		// Expected VBR pattern
	} row_t;

	// Pattern seed n puts {n, field index, A5C3} in every field
	localparam row_t Rows [NumRows] = '{
		'{3'b011, RegNone, 32'h0, 8'd1, RegVbr, RegGbr, 32'h0, 32'h0, 8'd0, 8'd0},
		'{3'b010, RegSr, 32'hDEAD0001, 8'd2, RegSsr, RegVbr, 32'h0, 32'h0, 8'd0, 8'd0},
		'{3'b001, RegR0, 32'h11110000, 8'd3, RegSr, RegR0, 32'h0, 32'h11110000, 8'd3, 8'd3},
		'{3'b000, RegR1, 32'h11110001, 8'd4, RegR0, RegPc, 32'h11110000, PcExp, 8'd0, 8'd0},
		'{3'b000, RegR9, 32'h99990009, 8'd5, RegLr, RegR1, 32'h0402A5C3, 32'h11110001, 8'd0, 8'd0},
		'{3'b000, RegR15, 32'hFFFF000F, 8'd6, RegR9, RegR15, 32'h99990009, 32'hFFFF000F, 8'd0, 8'd0},
		'{3'b000, RegGbr, 32'h6B6B0016, 8'd7, RegR15, RegGbr, 32'hFFFF000F, 32'h6B6B0016, 8'd0, 8'd0},
		'{3'b000, RegR3, 32'h33330003, 8'd8, RegGbr, RegTbr, 32'h6B6B0016, 32'h0708A5C3, 8'd0, 8'd0},
		'{3'b000, RegR3B, 32'hB3B30003, 8'd9, RegR3, RegR15, 32'h33330003, 32'h0800A5C3, 8'd0, 8'd0},
		'{3'b000, RegNone, 32'h0, 8'd10, RegR3B, RegR3, 32'hB3B30003, 32'h33330003, 8'd0, 8'd0},
		'{3'b101, RegNone, 32'h0, 8'd11, RegSsp, RegPc, 32'h0, PcExp, 8'd0, 8'd11},
		'{3'b100, RegNone, 32'h0, 8'd12, RegR3, RegR15, 32'hB3B30003, 32'h0, 8'd0, 8'd0},
		'{3'b100, RegNone, 32'h0, 8'd13, RegR3B, RegGbr, 32'h33330003, 32'h0C07A5C3, 8'd0, 8'd0},
		'{3'b100, RegNone, 32'h0, 8'd14, RegSsr, RegTbr, 32'h0B03A5C3, 32'h0D08A5C3, 8'd0, 8'd0},
		'{3'b011, RegNone, 32'h0, 8'd15, RegSpc, RegR3, 32'h0B01A5C3, 32'hB3B30003, 8'd14, 8'd14},
		'{3'b011, RegTbr, 32'h77770017, 8'd16, RegSsr, RegR3, 32'h0B03A5C3, 32'h33330003, 8'd14, 8'd14},
		'{3'b000, RegVbr, 32'h5B5B0013, 8'd17, RegTbr, RegVbr, 32'h0E08A5C3, 32'h0, 8'd0, 8'd0},
		'{3'b000, RegNone, 32'h0, 8'd18, RegImm, RegPc, ImmVal, PcExp, 8'd0, 8'd0},
		'{3'b101, RegZzr, 32'hFFFFFFFF, 8'd19, RegZzr, RegR3B, 32'h0, 32'h0, 8'd11, 8'd19}
	};

	logic clock = 1'b0;
	logic reset;
	logic [31:0] srVal;
	logic exHold;
	writePort_t write;
	sysNext_t exNext;
	logic [31:0] idImm;
	logic [31:0] idValPc;
	regId_t readIdM;
	regId_t readIdN;
	logic [31:0] readValM;
	logic [31:0] readValN;
	sysRegs_t sysOut;
	int cycles = 0;

	BsrRegGpr i_dut (.*);

	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("TB FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// Seed zero gives the all-zero reset state
	function automatic sysNext_t nextPattern(input logic [7:0] seed);
		sysNext_t p;
		p = '0;
		if (seed != 8'd0)
			for (int f = 0; f < 9; f++)
				p[287 - 32 * f -: 32] = {seed, 8'(f), 16'hA5C3};
		return p;
	endfunction

	task automatic reportError(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "Check failed");
	endtask

	task automatic compareValue(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			reportError($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic compareSys(input int row, input sysRegs_t got, input sysRegs_t exp);
		string names [9] = '{"sp", "pc", "pr", "sr", "vbr", "dlr", "dhr", "gbr", "tbr"};
		int bad;
		bad = -1;
		for (int f = 8; f >= 0; f--)
			if (got[287 - 32 * f -: 32] !== exp[287 - 32 * f -: 32])
				bad = f;				// Lowest index wins
		if (bad >= 0)
			reportError($sformatf("row %0d sysOut.%s is %h, expected %h", row, names[bad],
				got[287 - 32 * bad -: 32], exp[287 - 32 * bad -: 32]));
	endtask

	initial
	begin
		sysRegs_t expSys;
		sysNext_t vbrPat;
		reset = 1'b1;
		srVal = 32'h000000F0;
		exHold = 1'b0;
		write.id = RegNone;
		write.value = '0;
		exNext = '0;
		idImm = ImmVal;
		idValPc = PcVal;
		readIdM = RegZzr;
		readIdN = RegZzr;
		repeat (ResetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < NumRows; i++)
		begin
			srVal = Rows[i].flags[2] ? 32'h200000F0 : 32'h000000F0;	// Bit 29 is the bank
			exHold = Rows[i].flags[1];
			write.id = Rows[i].wrId;
			write.value = Rows[i].wrVal;
			exNext = nextPattern(Rows[i].seed);
			readIdM = Rows[i].idM;
			readIdN = Rows[i].idN;
			#1;
			compareValue($sformatf("row %0d readValM", i), readValM, Rows[i].expM);
			compareValue($sformatf("row %0d readValN", i), readValN, Rows[i].expN);
			@(posedge clock);
			#1;
			if (Rows[i].flags[0])
			begin
				vbrPat = nextPattern(Rows[i].vbrSeed);
				expSys = sysRegs_t'(nextPattern(Rows[i].sysSeed));
				expSys.vbr = vbrPat.vbr;		// VBR is never swapped
				compareSys(i, sysOut, expSys);
			end
			@(negedge clock);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/BsrRegGpr_assert.sv ====
// System register checks
`timescale 1ns/1ns
`default_nettype none

module BsrRegGprAssert (
	input wire logic clock,
	input wire logic reset,
	input wire logic exHold,
	input wire BsrRegPkg::writePort_t write,
	input wire BsrRegPkg::sysNext_t exNext,
	input wire BsrRegPkg::sysRegs_t sysRegs,
	input wire BsrRegPkg::shadowRegs_t shadows
);
	import BsrRegPkg::*;

	// Hold freezes the live and the shadow set
	holdKeepsState: assert property (@(posedge clock) disable iff (reset)
		exHold |=> (sysRegs == $past(sysRegs)) && (shadows == $past(shadows)))
		else $error("System registers changed while exHold was high");

	vbrFollowsNext: assert property (@(posedge clock) disable iff (reset)
		!exHold && (write.id != RegVbr) |=> sysRegs.vbr == $past(exNext.vbr))
		else $error("VBR did not take exNext.vbr");

	vbrTakesWrite: assert property (@(posedge clock) disable iff (reset)
		!exHold && (write.id == RegVbr) |=> sysRegs.vbr == $past(write.value))
		else $error("VBR did not take the write value");

endmodule

bind BsrSysRegFile BsrRegGprAssert i_assert (
	.clock(clock), .reset(reset), .exHold(exHold), .write(write),
	.exNext(exNext), .sysRegs(sysRegs), .shadows(shadows)
);

`default_nettype wire

// ==== verilog/BsrBankedLane.sv ====
// Banked register pair
`timescale 1ns/1ns
`default_nettype none

module BsrBankedLane (
	input wire logic clock,
	input BsrRegPkg::laneCtl_t ctl,
	input wire logic [31:0] value,
	output logic [31:0] valA,
	output logic [31:0] valB
);

	// Live half
	always_ff @(posedge clock)
	begin
		if (ctl.writeA)
			valA <= value;				// Write wins over swap
		else if (ctl.swap)
			valA <= valB;
	end

	// Alternate half
	always_ff @(posedge clock)
	begin
		if (ctl.writeB)
			valB <= value;
		else if (ctl.swap)
			valB <= valA;
	end

endmodule

`default_nettype wire

// ==== verilog/BsrReadPorts.sv ====
// Register read ports
`timescale 1ns/1ns
`default_nettype none

module BsrReadPorts (
	input BsrRegPkg::regId_t readIdM,
	input BsrRegPkg::regId_t readIdN,
	input BsrRegPkg::writePort_t write,
	input wire logic [31:0] laneA [BsrRegPkg::LaneCount],
	input wire logic [31:0] laneB [BsrRegPkg::LaneCount],
	input wire logic [31:0] upper [BsrRegPkg::UpperCount],
	input BsrRegPkg::sysRegs_t sysRegs,
	input BsrRegPkg::shadowRegs_t shadows,
	input wire logic [31:0] idImm,
	input wire logic [31:0] idValPc,
	output logic [31:0] readValM,
	output logic [31:0] readValN
);
	import BsrRegPkg::*;

	logic [31:0] gprM;
	logic [31:0] gprN;
	logic [31:0] pcRead;

	assign pcRead = idValPc + PcReadOffset;

	// Group 0, shared by both ports
	assign gprM = !readIdM.laneView.upper ? laneA[readIdM.laneView.lane] :
		(readIdM.laneView.lane == 3'd7) ? sysRegs.sp : upper[readIdM.laneView.lane];
	assign gprN = !readIdN.laneView.upper ? laneA[readIdN.laneView.lane] :
		(readIdN.laneView.lane == 3'd7) ? sysRegs.sp : upper[readIdN.laneView.lane];

	// Port M serves every id
	always_comb
	begin
		readValM = '0;
		case (readIdM.codeView.group)
			2'd0: readValM = gprM;
			2'd1:
			begin
				case (readIdM.codeView.code)
					RegPc[3:0]: readValM = pcRead;
					RegLr[3:0]: readValM = sysRegs.pr;
					RegSr[3:0]: readValM = sysRegs.sr;
					RegVbr[3:0]: readValM = sysRegs.vbr;
					RegDlr[3:0]: readValM = sysRegs.dlr;
					RegDhr[3:0]: readValM = sysRegs.dhr;
					RegGbr[3:0]: readValM = sysRegs.gbr;
					RegTbr[3:0]: readValM = sysRegs.tbr;
					default: readValM = '0;
				endcase
			end
			2'd2:
			begin
				case (readIdM.codeView.code)
					RegSpc[3:0]: readValM = shadows.spc;
					RegSlr[3:0]: readValM = shadows.spr;
					RegSsr[3:0]: readValM = shadows.ssr;
					RegSsp[3:0]: readValM = shadows.ssp;
					RegSdl[3:0]: readValM = shadows.sdl;
					RegSdh[3:0]: readValM = shadows.sdh;
					RegSgb[3:0]: readValM = shadows.sgb;
					RegStb[3:0]: readValM = shadows.stb;
					default: readValM = laneB[readIdM.laneView.lane];	// R0B to R7B
				endcase
			end
			default: readValM = (readIdM == RegImm) ? idImm : '0;	// ZZR and unused ids
		endcase
		if (readIdM == write.id && readIdM.codeView.group != 2'd3)
			readValM = write.value;				// Forward
	end

	// Port N serves R0 to R15, PC, GBR and TBR
	always_comb
	begin
		readValN = '0;
		if (readIdN.codeView.group == 2'd0)
			readValN = gprN;
		else if (readIdN == RegPc)
			readValN = pcRead;
		else if (readIdN == RegGbr)
			readValN = sysRegs.gbr;
		else if (readIdN == RegTbr)
			readValN = sysRegs.tbr;
		if (readIdN == write.id && (readIdN.codeView.group == 2'd0 || readIdN == RegPc ||
			readIdN == RegGbr || readIdN == RegTbr))
			readValN = write.value;
	end

endmodule

`default_nettype wire

// ==== verilog/BsrRegGpr.sv ====
// GPR and system register bank
`timescale 1ns/1ns
`default_nettype none

module BsrRegGpr (
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] srVal,
	input wire logic exHold,
	input BsrRegPkg::writePort_t write,
	input BsrRegPkg::sysNext_t exNext,
	input wire logic [31:0] idImm,
	input wire logic [31:0] idValPc,
	input BsrRegPkg::regId_t readIdM,
	input BsrRegPkg::regId_t readIdN,
	output logic [31:0] readValM,
	output logic [31:0] readValN,
	output BsrRegPkg::sysRegs_t sysOut
);
	import BsrRegPkg::*;

	laneCtl_t laneCtl [LaneCount];
	logic swap;
	logic [31:0] laneA [LaneCount];
	logic [31:0] laneB [LaneCount];
	logic [31:0] upper [UpperCount];
	shadowRegs_t shadows;

	BsrRegIdDecode i_decode (
		.clock(clock),
		.reset(reset),
		.srVal(srVal),
		.write(write),
		.laneCtl(laneCtl),
		.swap(swap)
	);

	// Banked R0 to R7
	for (genvar i = 0; i < LaneCount; i++)
	begin : g_lane
		BsrBankedLane i_lane (
			.clock(clock),
			.ctl(laneCtl[i]),
			.value(write.value),
			.valA(laneA[i]),
			.valB(laneB[i])
		);
	end

	BsrSysRegFile i_sysFile (
		.clock(clock),
		.reset(reset),
		.exHold(exHold),
		.swap(swap),
		.write(write),
		.exNext(exNext),
		.sysRegs(sysOut),
		.shadows(shadows),
		.upper(upper)
	);

	BsrReadPorts i_readPorts (
		.readIdM(readIdM),
		.readIdN(readIdN),
		.write(write),
		.laneA(laneA),
		.laneB(laneB),
		.upper(upper),
		.sysRegs(sysOut),
		.shadows(shadows),
		.idImm(idImm),
		.idValPc(idValPc),
		.readValM(readValM),
		.readValN(readValN)
	);

endmodule

`default_nettype wire

// ==== verilog/BsrRegIdDecode.sv ====
// Lane control decoder
`timescale 1ns/1ns
`default_nettype none

module BsrRegIdDecode (
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] srVal,
	input BsrRegPkg::writePort_t write,
	output BsrRegPkg::laneCtl_t laneCtl [BsrRegPkg::LaneCount],
	output logic swap
);
	import BsrRegPkg::*;

	logic prevBank;
	logic bankReq;

	assign bankReq = srVal[SrBankBit];
	assign swap = bankReq ^ prevBank;			// Bank bit changed

	always_ff @(posedge clock)
	begin
		if (reset)
			prevBank <= 1'b0;
		else
			prevBank <= bankReq;
	end

	// Only ids 0x00-0x07 and 0x20-0x27 land in a lane
	always_comb
	begin
		for (int i = 0; i < LaneCount; i++)
		begin
			laneCtl[i].swap = swap;
			laneCtl[i].writeA = (write.id.laneView.group == 2'd0) &&
				!write.id.laneView.upper && (write.id.laneView.lane == 3'(i));
			laneCtl[i].writeB = (write.id.laneView.group == 2'd2) &&
				!write.id.laneView.upper && (write.id.laneView.lane == 3'(i));
		end
	end

endmodule

`default_nettype wire

// ==== verilog/BsrRegPkg.sv ====
// Register bank definitions
`default_nettype none

package BsrRegPkg;
	localparam int RegIdWidth = 6;
	localparam int LaneCount = 8;
	localparam int UpperCount = 7;			// R8 to R14
	localparam int SrBankBit = 29;
	localparam logic [31:0] PcReadOffset = 32'd2;

	localparam logic [RegIdWidth-1:0] RegR0 = 6'h00;
	localparam logic [RegIdWidth-1:0] RegR1 = 6'h01;
	localparam logic [RegIdWidth-1:0] RegR2 = 6'h02;
	localparam logic [RegIdWidth-1:0] RegR3 = 6'h03;
	localparam logic [RegIdWidth-1:0] RegR4 = 6'h04;
	localparam logic [RegIdWidth-1:0] RegR5 = 6'h05;
	localparam logic [RegIdWidth-1:0] RegR6 = 6'h06;
	localparam logic [RegIdWidth-1:0] RegR7 = 6'h07;
	localparam logic [RegIdWidth-1:0] RegR8 = 6'h08;
	localparam logic [RegIdWidth-1:0] RegR9 = 6'h09;
	localparam logic [RegIdWidth-1:0] RegR10 = 6'h0A;
	localparam logic [RegIdWidth-1:0] RegR11 = 6'h0B;
	localparam logic [RegIdWidth-1:0] RegR12 = 6'h0C;
	localparam logic [RegIdWidth-1:0] RegR13 = 6'h0D;
	localparam logic [RegIdWidth-1:0] RegR14 = 6'h0E;
	localparam logic [RegIdWidth-1:0] RegR15 = 6'h0F;	// Stack pointer

	localparam logic [RegIdWidth-1:0] RegPc = 6'h10;
	localparam logic [RegIdWidth-1:0] RegLr = 6'h11;
	localparam logic [RegIdWidth-1:0] RegSr = 6'h12;
	localparam logic [RegIdWidth-1:0] RegVbr = 6'h13;
	localparam logic [RegIdWidth-1:0] RegDlr = 6'h14;
	localparam logic [RegIdWidth-1:0] RegDhr = 6'h15;
	localparam logic [RegIdWidth-1:0] RegGbr = 6'h16;
	localparam logic [RegIdWidth-1:0] RegTbr = 6'h17;

	localparam logic [RegIdWidth-1:0] RegR0B = 6'h20;	// Alternate bank
	localparam logic [RegIdWidth-1:0] RegR1B = 6'h21;
	localparam logic [RegIdWidth-1:0] RegR2B = 6'h22;
	localparam logic [RegIdWidth-1:0] RegR3B = 6'h23;
	localparam logic [RegIdWidth-1:0] RegR4B = 6'h24;
	localparam logic [RegIdWidth-1:0] RegR5B = 6'h25;
	localparam logic [RegIdWidth-1:0] RegR6B = 6'h26;
	localparam logic [RegIdWidth-1:0] RegR7B = 6'h27;

	localparam logic [RegIdWidth-1:0] RegSpc = 6'h28;
	localparam logic [RegIdWidth-1:0] RegSlr = 6'h29;
	localparam logic [RegIdWidth-1:0] RegSsr = 6'h2A;
	localparam logic [RegIdWidth-1:0] RegSsp = 6'h2B;
	localparam logic [RegIdWidth-1:0] RegSdl = 6'h2C;
	localparam logic [RegIdWidth-1:0] RegSdh = 6'h2D;
	localparam logic [RegIdWidth-1:0] RegSgb = 6'h2E;
	localparam logic [RegIdWidth-1:0] RegStb = 6'h2F;

	localparam logic [RegIdWidth-1:0] RegImm = 6'h30;
	localparam logic [RegIdWidth-1:0] RegZzr = 6'h31;	// Reads zero
	localparam logic [RegIdWidth-1:0] RegNone = 6'h3F;	// No write

	typedef struct packed {logic [1:0] group; logic upper; logic [2:0] lane;} laneView_t;
	typedef struct packed {logic [1:0] group; logic [3:0] code;} codeView_t;
	typedef union packed {laneView_t laneView; codeView_t codeView;} regId_t;

	typedef struct packed {regId_t id; logic [31:0] value;} writePort_t;
	typedef struct packed {
		logic [31:0] sp, pc, pr, sr, vbr, dlr, dhr, gbr, tbr;
	} sysNext_t;
	typedef struct packed {
		logic [31:0] sp, pc, pr, sr, vbr, dlr, dhr, gbr, tbr;
	} sysRegs_t;
	typedef struct packed {
		logic [31:0] spc, spr, ssr, ssp, sdl, sdh, sgb, stb;
	} shadowRegs_t;
	typedef struct packed {logic writeA; logic writeB; logic swap;} laneCtl_t;
endpackage

`default_nettype wire

// ==== verilog/BsrSysRegFile.sv ====
// System register file
`timescale 1ns/1ns
`default_nettype none

module BsrSysRegFile (
	input wire logic clock,
	input wire logic reset,
	input wire logic exHold,
	input wire logic swap,
	input BsrRegPkg::writePort_t write,
	input BsrRegPkg::sysNext_t exNext,
	output BsrRegPkg::sysRegs_t sysRegs,
	output BsrRegPkg::shadowRegs_t shadows,
	output logic [31:0] upper [BsrRegPkg::UpperCount]
);
	import BsrRegPkg::*;

	// Write value if the write port targets id, else the other value
	function automatic logic [31:0] wrOr(input regId_t id, input logic [31:0] other);
		if (write.id.codeView.group == id.codeView.group &&
			write.id.codeView.code == id.codeView.code)
			return write.value;
		return other;
	endfunction

	// R8 to R14, independent of hold
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < UpperCount; i++)
		begin
			if (write.id.codeView.group == 2'd0 && write.id.codeView.code == 4'(RegR8 + i))
				upper[i] <= write.value;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sysRegs <= '0;
			shadows <= '0;
		end
		else if (!exHold)
		begin
			sysRegs.vbr <= wrOr(RegVbr, exNext.vbr);	// Never banked
			if (swap)
			begin
				sysRegs.sp <= wrOr(RegR15, shadows.ssp);
				sysRegs.pc <= wrOr(RegPc, shadows.spc);
				sysRegs.pr <= wrOr(RegLr, shadows.spr);
				sysRegs.sr <= wrOr(RegSr, shadows.ssr);
				sysRegs.dlr <= wrOr(RegDlr, shadows.sdl);
				sysRegs.dhr <= wrOr(RegDhr, shadows.sdh);
				sysRegs.gbr <= wrOr(RegGbr, shadows.sgb);
				sysRegs.tbr <= wrOr(RegTbr, shadows.stb);
				shadows.spc <= wrOr(RegSpc, exNext.pc);		// Save outgoing set
				shadows.spr <= wrOr(RegSlr, exNext.pr);
				shadows.ssr <= wrOr(RegSsr, exNext.sr);
				shadows.ssp <= wrOr(RegSsp, exNext.sp);
				shadows.sdl <= wrOr(RegSdl, exNext.dlr);
				shadows.sdh <= wrOr(RegSdh, exNext.dhr);
				shadows.sgb <= wrOr(RegSgb, exNext.gbr);
				shadows.stb <= wrOr(RegStb, exNext.tbr);
			end
			else
			begin
				sysRegs.sp <= wrOr(RegR15, exNext.sp);
				sysRegs.pc <= wrOr(RegPc, exNext.pc);
				sysRegs.pr <= wrOr(RegLr, exNext.pr);
				sysRegs.sr <= wrOr(RegSr, exNext.sr);
				sysRegs.dlr <= wrOr(RegDlr, exNext.dlr);
				sysRegs.dhr <= wrOr(RegDhr, exNext.dhr);
				sysRegs.gbr <= wrOr(RegGbr, exNext.gbr);
				sysRegs.tbr <= wrOr(RegTbr, exNext.tbr);
				shadows.spc <= wrOr(RegSpc, shadows.spc);
				shadows.spr <= wrOr(RegSlr, shadows.spr);
				shadows.ssr <= wrOr(RegSsr, shadows.ssr);
				shadows.ssp <= wrOr(RegSsp, shadows.ssp);
				shadows.sdl <= wrOr(RegSdl, shadows.sdl);
				shadows.sdh <= wrOr(RegSdh, shadows.sdh);
				shadows.sgb <= wrOr(RegSgb, shadows.sgb);
				shadows.stb <= wrOr(RegStb, shadows.stb);
			end
		end
	end

endmodule

`default_nettype wire
